// ==== verilog/dma_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes and register map of the 2D DMA engine.
// Every block of the core takes its widths from here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dma_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned LenWidth     = 16;
  localparam int unsigned IdWidth      = 32;
  localparam int unsigned RepsWidth    = 32;
  localparam int unsigned WordBytes    = DataWidth / 8;

  // job fifo sizing.
  localparam int unsigned JobFifoDepth = 4;
  localparam int unsigned FifoPtrWidth = $clog2(JobFifoDepth);
  localparam int unsigned FifoCntWidth = $clog2(JobFifoDepth + 1);

  // flattened job is {src, dst, len, src_stride, dst_stride, reps}.
  localparam int unsigned JobWidth     = 4 * AddrWidth + LenWidth + RepsWidth;

  // byte offsets on the register bus.
  localparam logic [AddrWidth-1:0] RegSrc       = 32'h00;
  localparam logic [AddrWidth-1:0] RegDst       = 32'h04;
  localparam logic [AddrWidth-1:0] RegLen       = 32'h08;
  localparam logic [AddrWidth-1:0] RegSrcStride = 32'h0C;
  localparam logic [AddrWidth-1:0] RegDstStride = 32'h10;
  localparam logic [AddrWidth-1:0] RegReps      = 32'h14;
  // reading this one launches the job.
  localparam logic [AddrWidth-1:0] RegNextId    = 32'h18;
  localparam logic [AddrWidth-1:0] RegDoneId    = 32'h1C;
  localparam logic [AddrWidth-1:0] RegStatus    = 32'h20;

endpackage

// ==== verilog/dma_reg_frontend.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file of the DMA. Software writes the job settings,
// then reads the next-ID register to launch the job.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_reg_frontend (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          reg_valid_i,
  input  logic                          reg_write_i,
  input  logic [dma_pkg::AddrWidth-1:0] reg_addr_i,
  input  logic [dma_pkg::DataWidth-1:0] reg_wdata_i,
  output logic                          reg_ready_o,
  output logic [dma_pkg::DataWidth-1:0] reg_rdata_o,
  output logic [dma_pkg::JobWidth-1:0]  job_o,
  output logic                          job_valid_o,
  input  logic                          job_ready_i,
  input  logic [dma_pkg::IdWidth-1:0]   next_id_i,
  input  logic [dma_pkg::IdWidth-1:0]   done_id_i,
  input  logic                          busy_i
);

  import dma_pkg::*;

  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  logic [LenWidth-1:0]  len_q;
  logic [AddrWidth-1:0] src_stride_q;
  logic [AddrWidth-1:0] dst_stride_q;
  logic [RepsWidth-1:0] reps_q;
  logic                 launch_rd;
  logic                 wr_en;

  // a launch read waits for room in the job fifo.
  assign launch_rd   = reg_valid_i && !reg_write_i && (reg_addr_i == RegNextId);
  assign reg_ready_o = !(launch_rd && !job_ready_i);
  assign job_valid_o = launch_rd;
  assign wr_en       = reg_valid_i && reg_write_i;

  assign job_o = {src_q, dst_q, len_q, src_stride_q, dst_stride_q, reps_q};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        RegSrc:       src_q        <= reg_wdata_i[AddrWidth-1:0];
        RegDst:       dst_q        <= reg_wdata_i[AddrWidth-1:0];
        RegLen:       len_q        <= reg_wdata_i[LenWidth-1:0];
        RegSrcStride: src_stride_q <= reg_wdata_i[AddrWidth-1:0];
        RegDstStride: dst_stride_q <= reg_wdata_i[AddrWidth-1:0];
        RegReps:      reps_q       <= reg_wdata_i[RepsWidth-1:0];
        default: ;
      endcase
    end
  end

  // unmapped offsets read as zero.
  always_comb begin
    reg_rdata_o = '0;
    if (reg_valid_i && !reg_write_i) begin
      case (reg_addr_i)
        RegSrc:       reg_rdata_o = DataWidth'(src_q);
        RegDst:       reg_rdata_o = DataWidth'(dst_q);
        RegLen:       reg_rdata_o = DataWidth'(len_q);
        RegSrcStride: reg_rdata_o = DataWidth'(src_stride_q);
        RegDstStride: reg_rdata_o = DataWidth'(dst_stride_q);
        RegReps:      reg_rdata_o = DataWidth'(reps_q);
        RegNextId:    reg_rdata_o = DataWidth'(next_id_i);
        RegDoneId:    reg_rdata_o = DataWidth'(done_id_i);
        RegStatus:    reg_rdata_o = DataWidth'(busy_i);
        default:      reg_rdata_o = '0;
      endcase
    end
  end

endmodule

// ==== verilog/dma_job_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready FIFO that queues launched jobs for the midend.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_job_fifo (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [dma_pkg::JobWidth-1:0] data_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  output logic [dma_pkg::JobWidth-1:0] data_o,
  output logic                         valid_o,
  input  logic                         ready_i
);

  import dma_pkg::*;

  logic [JobWidth-1:0]     mem_q [JobFifoDepth];
  logic [FifoPtrWidth-1:0] wr_ptr_q;
  logic [FifoPtrWidth-1:0] rd_ptr_q;
  logic [FifoCntWidth-1:0] count_q;
  logic                    push;
  logic                    pop;

  assign ready_o = (count_q != FifoCntWidth'(JobFifoDepth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == FifoPtrWidth'(JobFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FifoPtrWidth'(JobFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count moves only when exactly one side fires.
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // a full fifo has its write pointer wrapped onto the read pointer.
  a_full_ptrs_meet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q == FifoCntWidth'(JobFifoDepth)) |-> (wr_ptr_q == rd_ptr_q));

endmodule

// ==== verilog/dma_nd_midend.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Splits a 2D job into 1D bursts for the backend and signals
// job retirement after the final burst completes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_nd_midend (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [dma_pkg::JobWidth-1:0]  job_i,
  input  logic                          job_valid_i,
  output logic                          job_ready_o,
  output logic [dma_pkg::AddrWidth-1:0] burst_src_o,
  output logic [dma_pkg::AddrWidth-1:0] burst_dst_o,
  output logic [dma_pkg::LenWidth-1:0]  burst_len_o,
  output logic                          burst_valid_o,
  input  logic                          burst_ready_i,
  input  logic                          burst_done_i,
  output logic                          retire_o,
  output logic                          busy_o
);

  import dma_pkg::*;

  logic [AddrWidth-1:0] job_src;
  logic [AddrWidth-1:0] job_dst;
  logic [LenWidth-1:0]  job_len;
  logic [AddrWidth-1:0] job_src_stride;
  logic [AddrWidth-1:0] job_dst_stride;
  logic [RepsWidth-1:0] job_reps;

  logic                 active_q;
  logic                 burst_valid_q;
  logic                 outstanding_q;
  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  logic [LenWidth-1:0]  len_q;
  logic [AddrWidth-1:0] src_stride_q;
  logic [AddrWidth-1:0] dst_stride_q;
  logic [RepsWidth-1:0] reps_left_q;
  logic                 take_job;
  logic                 last_rep;

  assign {job_src, job_dst, job_len, job_src_stride, job_dst_stride, job_reps} = job_i;

  assign job_ready_o   = !active_q;
  assign take_job      = job_valid_i && job_ready_o;
  assign last_rep      = (reps_left_q == RepsWidth'(1));
  assign burst_src_o   = src_q;
  assign burst_dst_o   = dst_q;
  assign burst_len_o   = len_q;
  assign burst_valid_o = burst_valid_q;
  assign retire_o      = burst_done_i && last_rep;
  assign busy_o        = active_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q      <= 1'b0;
      burst_valid_q <= 1'b0;
      outstanding_q <= 1'b0;
      src_q         <= '0;
      dst_q         <= '0;
      len_q         <= '0;
      src_stride_q  <= '0;
      dst_stride_q  <= '0;
      reps_left_q   <= '0;
    end else begin
      if (take_job) begin
        active_q      <= 1'b1;
        burst_valid_q <= 1'b1;
        src_q         <= job_src;
        dst_q         <= job_dst;
        len_q         <= job_len;
        src_stride_q  <= job_src_stride;
        dst_stride_q  <= job_dst_stride;
        // zero reps still moves one burst.
        reps_left_q   <= (job_reps == '0) ? RepsWidth'(1) : job_reps;
      end
      if (burst_valid_q && burst_ready_i) begin
        burst_valid_q <= 1'b0;
        outstanding_q <= 1'b1;
      end
      if (burst_done_i) begin
        outstanding_q <= 1'b0;
        src_q         <= src_q + src_stride_q;
        dst_q         <= dst_q + dst_stride_q;
        reps_left_q   <= reps_left_q - 1'b1;
        if (last_rep) begin
          active_q <= 1'b0;
        end else begin
          burst_valid_q <= 1'b1;
        end
      end
    end
  end

  a_done_needs_burst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    burst_done_i |-> outstanding_q);

endmodule

// ==== verilog/dma_backend.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Copies one burst of words over the memory port, one read
// followed by one write per word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_backend (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [dma_pkg::AddrWidth-1:0] burst_src_i,
  input  logic [dma_pkg::AddrWidth-1:0] burst_dst_i,
  input  logic [dma_pkg::LenWidth-1:0]  burst_len_i,
  input  logic                          burst_valid_i,
  output logic                          burst_ready_o,
  output logic                          burst_done_o,
  output logic                          mem_rd_req_o,
  output logic [dma_pkg::AddrWidth-1:0] mem_rd_addr_o,
  input  logic                          mem_rd_valid_i,
  input  logic [dma_pkg::DataWidth-1:0] mem_rd_data_i,
  output logic                          mem_wr_req_o,
  output logic [dma_pkg::AddrWidth-1:0] mem_wr_addr_o,
  output logic [dma_pkg::DataWidth-1:0] mem_wr_data_o,
  input  logic                          mem_wr_gnt_i,
  output logic                          busy_o
);

  import dma_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StRead,
    StWrite,
    StDone
  } state_e;

  state_e               state_q;
  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  logic [LenWidth-1:0]  words_left_q;
  logic [DataWidth-1:0] data_q;

  assign burst_ready_o = (state_q == StIdle);
  assign burst_done_o  = (state_q == StDone);
  assign busy_o        = (state_q != StIdle);
  assign mem_rd_req_o  = (state_q == StRead);
  assign mem_rd_addr_o = src_q;
  assign mem_wr_req_o  = (state_q == StWrite);
  assign mem_wr_addr_o = dst_q;
  assign mem_wr_data_o = data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= StIdle;
      src_q        <= '0;
      dst_q        <= '0;
      words_left_q <= '0;
      data_q       <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (burst_valid_i) begin
            src_q        <= burst_src_i;
            dst_q        <= burst_dst_i;
            words_left_q <= burst_len_i;
            // empty burst skips the memory entirely.
            state_q      <= (burst_len_i == '0) ? StDone : StRead;
          end
        end
        StRead: begin
          if (mem_rd_valid_i) begin
            data_q  <= mem_rd_data_i;
            state_q <= StWrite;
          end
        end
        StWrite: begin
          if (mem_wr_gnt_i) begin
            src_q        <= src_q + AddrWidth'(WordBytes);
            dst_q        <= dst_q + AddrWidth'(WordBytes);
            words_left_q <= words_left_q - 1'b1;
            state_q      <= (words_left_q == LenWidth'(1)) ? StDone : StRead;
          end
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

  a_one_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mem_rd_req_o && mem_wr_req_o));

endmodule

// ==== verilog/dma_transfer_id_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counts issued and retired jobs. Software polls the done
// count against the ID it got at launch.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_transfer_id_gen (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        issue_i,
  input  logic                        retire_i,
  output logic [dma_pkg::IdWidth-1:0] next_id_o,
  output logic [dma_pkg::IdWidth-1:0] done_id_o
);

  // first launched job gets ID 1.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_id_o <= 1;
    end else if (issue_i) begin
      next_id_o <= next_id_o + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_id_o <= '0;
    end else if (retire_i) begin
      done_id_o <= done_id_o + 1'b1;
    end
  end

  // retire may only follow an earlier issue.
  a_retire_after_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    retire_i |-> (done_id_o != next_id_o));

endmodule

// ==== verilog/dma_core_wrap.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the 2D DMA core. Register bus in, memory port out;
// connects frontend, job FIFO, midend, backend and ID counters.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_core_wrap (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          reg_valid_i,
  input  logic                          reg_write_i,
  input  logic [dma_pkg::AddrWidth-1:0] reg_addr_i,
  input  logic [dma_pkg::DataWidth-1:0] reg_wdata_i,
  output logic                          reg_ready_o,
  output logic [dma_pkg::DataWidth-1:0] reg_rdata_o,
  output logic                          mem_rd_req_o,
  output logic [dma_pkg::AddrWidth-1:0] mem_rd_addr_o,
  input  logic                          mem_rd_valid_i,
  input  logic [dma_pkg::DataWidth-1:0] mem_rd_data_i,
  output logic                          mem_wr_req_o,
  output logic [dma_pkg::AddrWidth-1:0] mem_wr_addr_o,
  output logic [dma_pkg::DataWidth-1:0] mem_wr_data_o,
  input  logic                          mem_wr_gnt_i
);

  import dma_pkg::*;

  logic [JobWidth-1:0]  fe_job;
  logic                 fe_job_valid;
  logic                 fe_job_ready;
  logic [JobWidth-1:0]  me_job;
  logic                 me_job_valid;
  logic                 me_job_ready;
  logic [AddrWidth-1:0] be_src;
  logic [AddrWidth-1:0] be_dst;
  logic [LenWidth-1:0]  be_len;
  logic                 be_valid;
  logic                 be_ready;
  logic                 be_done;
  logic                 be_busy;
  logic                 me_busy;
  logic                 issue_id;
  logic                 retire_id;
  logic [IdWidth-1:0]   next_id;
  logic [IdWidth-1:0]   done_id;

  assign issue_id = fe_job_valid && fe_job_ready;

  dma_reg_frontend i_frontend (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ready_o (reg_ready_o),
    .reg_rdata_o (reg_rdata_o),
    .job_o       (fe_job),
    .job_valid_o (fe_job_valid),
    .job_ready_i (fe_job_ready),
    .next_id_i   (next_id),
    .done_id_i   (done_id),
    .busy_i      (me_busy | be_busy)
  );

  dma_job_fifo i_job_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (fe_job),
    .valid_i (fe_job_valid),
    .ready_o (fe_job_ready),
    .data_o  (me_job),
    .valid_o (me_job_valid),
    .ready_i (me_job_ready)
  );

  dma_nd_midend i_midend (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .job_i         (me_job),
    .job_valid_i   (me_job_valid),
    .job_ready_o   (me_job_ready),
    .burst_src_o   (be_src),
    .burst_dst_o   (be_dst),
    .burst_len_o   (be_len),
    .burst_valid_o (be_valid),
    .burst_ready_i (be_ready),
    .burst_done_i  (be_done),
    .retire_o      (retire_id),
    .busy_o        (me_busy)
  );

  dma_backend i_backend (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .burst_src_i    (be_src),
    .burst_dst_i    (be_dst),
    .burst_len_i    (be_len),
    .burst_valid_i  (be_valid),
    .burst_ready_o  (be_ready),
    .burst_done_o   (be_done),
    .mem_rd_req_o   (mem_rd_req_o),
    .mem_rd_addr_o  (mem_rd_addr_o),
    .mem_rd_valid_i (mem_rd_valid_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .mem_wr_req_o   (mem_wr_req_o),
    .mem_wr_addr_o  (mem_wr_addr_o),
    .mem_wr_data_o  (mem_wr_data_o),
    .mem_wr_gnt_i   (mem_wr_gnt_i),
    .busy_o         (be_busy)
  );

  dma_transfer_id_gen i_transfer_id_gen (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .issue_i   (issue_id),
    .retire_i  (retire_id),
    .next_id_o (next_id),
    .done_id_o (done_id)
  );

endmodule

// ==== dv/tb_dma_core_wrap.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the 2D DMA core. Programs random jobs over the
// register bus, serves the memory port from a word array with
// random latency and compares memory against a shadow copy.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_dma_core_wrap;

  import dma_pkg::*;

  localparam int MemWords    = 1024;
  localparam int MaxJobWords = 16 * 4;
  // worst case word count over the 1d, 2d, queue, zero and busy jobs.
  localparam int TotalWords  = 16 + 2 * MaxJobWords + 6 * MaxJobWords + 2 * 16 + MaxJobWords;
  localparam int WatchdogCycles = TotalWords * 20 + 2000;
  localparam int StimStream  = 0;
  localparam int MemStream   = 1;

  logic                 clk;
  logic                 rst_n;
  logic                 reg_valid;
  logic                 reg_write;
  logic [AddrWidth-1:0] reg_addr;
  logic [DataWidth-1:0] reg_wdata;
  logic                 reg_ready;
  logic [DataWidth-1:0] reg_rdata;
  logic                 mem_rd_req;
  logic [AddrWidth-1:0] mem_rd_addr;
  logic                 mem_rd_valid;
  logic [DataWidth-1:0] mem_rd_data;
  logic                 mem_wr_req;
  logic [AddrWidth-1:0] mem_wr_addr;
  logic [DataWidth-1:0] mem_wr_data;
  logic                 mem_wr_gnt;

  logic [31:0] mem [MemWords];
  logic [31:0] shadow [MemWords];
  logic [15:0] lfsr_q [2];
  int          rd_wait = -1;
  int          wr_wait = -1;

  // job settings shared by the launch and the model.
  logic [31:0] j_src;
  logic [31:0] j_dst;
  logic [31:0] j_len;
  logic [31:0] j_ss;
  logic [31:0] j_ds;
  logic [31:0] j_reps;
  logic [31:0] exp_id;

  int test_errors = 0;
  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;

  dma_core_wrap dma_core_wrap_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_valid_i    (reg_valid),
    .reg_write_i    (reg_write),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_ready_o    (reg_ready),
    .reg_rdata_o    (reg_rdata),
    .mem_rd_req_o   (mem_rd_req),
    .mem_rd_addr_o  (mem_rd_addr),
    .mem_rd_valid_i (mem_rd_valid),
    .mem_rd_data_i  (mem_rd_data),
    .mem_wr_req_o   (mem_wr_req),
    .mem_wr_addr_o  (mem_wr_addr),
    .mem_wr_data_o  (mem_wr_data),
    .mem_wr_gnt_i   (mem_wr_gnt)
  );

  always #4 clk = ~clk;

  // 16-bit fibonacci lfsr with taps 16 14 13 11 and one step per bit.
  function automatic logic [31:0] lfsr_take(input int stream, input int nbits);
    logic [31:0] value;
    logic [15:0] s;
    int          i;
    value = '0;
    s = lfsr_q[stream];
    for (i = 0; i < nbits; i++) begin
      s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
      value = {value[30:0], s[0]};
    end
    lfsr_q[stream] = s;
    return value;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return {~idx[15:0], idx[15:0]} ^ 32'h1357_9BDF;
  endfunction

  // the memory port model answers on the falling edge.
  always @(negedge clk) begin
    mem_rd_valid = 1'b0;
    mem_wr_gnt   = 1'b0;
    if (rst_n && mem_rd_req) begin
      if (rd_wait < 0) begin
        rd_wait = lfsr_take(MemStream, 2);
      end
      if (rd_wait == 0) begin
        mem_rd_valid = 1'b1;
        mem_rd_data  = mem[mem_rd_addr[11:2]];
        rd_wait      = -1;
      end else begin
        rd_wait--;
      end
    end
    if (rst_n && mem_wr_req) begin
      if (wr_wait < 0) begin
        wr_wait = lfsr_take(MemStream, 2) % 3;
      end
      if (wr_wait == 0) begin
        mem_wr_gnt = 1'b1;
        mem[mem_wr_addr[11:2]] = mem_wr_data;
        wr_wait = -1;
      end else begin
        wr_wait--;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d errors", name, test_errors);
    test_count++;
    test_errors = 0;
  endtask

  // stall counts the cycles a bus transfer waits for ready.
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int stall);
    stall = 0;
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    #1;
    while (!reg_ready) begin
      stall++;
      @(negedge clk);
      #1;
    end
    rdata = reg_rdata;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    int          stall;
    bus_access(1'b1, addr, data, unused, stall);
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    int stall;
    bus_access(1'b0, addr, '0, data, stall);
  endtask

  // sources lie in the lower half of memory and destinations in the upper half.
  task automatic random_job;
    j_src  = lfsr_take(StimStream, 8) << 2;
    j_dst  = (32'd512 + lfsr_take(StimStream, 8)) << 2;
    j_len  = 1 + lfsr_take(StimStream, 4);
    j_ss   = (16 + lfsr_take(StimStream, 5)) << 2;
    j_ds   = (16 + lfsr_take(StimStream, 5)) << 2;
    j_reps = 1 + lfsr_take(StimStream, 2);
  endtask

  task automatic model_copy;
    int          k;
    int          w;
    int          nreps;
    logic [31:0] s;
    logic [31:0] d;
    nreps = (j_reps == 0) ? 1 : j_reps;
    for (k = 0; k < nreps; k++) begin
      for (w = 0; w < j_len[15:0]; w++) begin
        s = j_src + k * j_ss + 4 * w;
        d = j_dst + k * j_ds + 4 * w;
        shadow[d[11:2]] = shadow[s[11:2]];
      end
    end
  endtask

  task automatic launch_job(input string name, output logic [31:0] id, output int stall);
    write_reg(RegSrc, j_src);
    write_reg(RegDst, j_dst);
    write_reg(RegLen, j_len);
    write_reg(RegSrcStride, j_ss);
    write_reg(RegDstStride, j_ds);
    write_reg(RegReps, j_reps);
    bus_access(1'b0, RegNextId, '0, id, stall);
    check_value(name, exp_id, id);
    exp_id++;
    model_copy();
  endtask

  task automatic wait_done(input logic [31:0] id);
    logic [31:0] done;
    done = '0;
    while (done < id) begin
      read_reg(RegDoneId, done);
    end
  endtask

  task automatic compare_memory(input string name);
    int i;
    for (i = 0; i < MemWords; i++) begin
      check_value(name, shadow[i], mem[i]);
    end
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired: the DMA did not finish within %0d cycles", WatchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic [31:0] id;
    logic [31:0] written [6];
    int          stall;
    int          i;
    int          q;
    clk          = 1'b0;
    rst_n        = 1'b0;
    reg_valid    = 1'b0;
    reg_write    = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    mem_rd_valid = 1'b0;
    mem_rd_data  = '0;
    mem_wr_gnt   = 1'b0;
    lfsr_q[StimStream] = 16'd31;
    lfsr_q[MemStream]  = 16'd31;
    exp_id = 1;
    for (i = 0; i < MemWords; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    read_reg(RegDoneId, rdata);
    check_value("regs", 32'd0, rdata);
    read_reg(RegStatus, rdata);
    check_value("regs", 32'd0, rdata);
    for (i = 0; i < 6; i++) begin
      written[i] = lfsr_take(StimStream, 32);
      write_reg(RegSrc + AddrWidth'(4 * i), written[i]);
    end
    for (i = 0; i < 6; i++) begin
      read_reg(RegSrc + AddrWidth'(4 * i), rdata);
      check_value("regs", (i == 2) ? (written[i] & 32'h0000_FFFF) : written[i], rdata);
    end
    end_test("regs");

    random_job();
    j_reps = 1;
    launch_job("copy_1d", id, stall);
    wait_done(id);
    compare_memory("copy_1d");
    end_test("copy_1d");

    for (q = 0; q < 2; q++) begin
      random_job();
      launch_job("copy_2d", id, stall);
      wait_done(id);
      compare_memory("copy_2d");
    end
    end_test("copy_2d");

    // a long job holds the midend so the next five fill the fifo.
    random_job();
    j_len  = 16;
    j_reps = 4;
    launch_job("queue", id, stall);
    for (q = 0; q < 5; q++) begin
      random_job();
      launch_job("queue", id, stall);
      check_value("queue", (q == 4) ? 32'd1 : 32'd0, (stall != 0) ? 32'd1 : 32'd0);
    end
    wait_done(id);
    read_reg(RegDoneId, rdata);
    check_value("queue", id, rdata);
    compare_memory("queue");
    end_test("queue");

    random_job();
    j_len = 0;
    launch_job("zero", id, stall);
    wait_done(id);
    compare_memory("zero");
    random_job();
    j_reps = 0;
    launch_job("zero", id, stall);
    wait_done(id);
    compare_memory("zero");
    end_test("zero");

    random_job();
    j_len  = 16;
    j_reps = 4;
    launch_job("busy", id, stall);
    repeat (2) @(negedge clk);
    read_reg(RegStatus, rdata);
    check_value("busy", 32'd1, rdata & 32'd1);
    wait_done(id);
    read_reg(RegStatus, rdata);
    check_value("busy", 32'd0, rdata & 32'd1);
    compare_memory("busy");
    end_test("busy");

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/dma_pkg.sv
verilog/dma_reg_frontend.sv
verilog/dma_job_fifo.sv
verilog/dma_nd_midend.sv
verilog/dma_backend.sv
verilog/dma_transfer_id_gen.sv
verilog/dma_core_wrap.sv
dv/tb_dma_core_wrap.sv
